//--- Makefile
TOP := tbSetAssocCache

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

# Build and run, a $fatal gives a failing exit status
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- cacheController.sv
`timescale 1ns/1ps

module cacheController #(
    parameter int setIndexBits = 4
) (
    input  logic rwArbiterCacheBus,
    input  logic rst,
    // Core side
    input  cachePkg::coreReqT coreReq,
    input  logic coreReqValid,
    output logic coreReqReady,
    output cachePkg::wordT coreRespData,
    output logic coreRespValid,
    input  logic coreRespReady,
    // Memory side
    output cachePkg::memReqT memReq,
    output logic memReqValid,
    input  logic memReqReady,
    input  cachePkg::wordT memRespData,
    input  logic memRespValid,
    // Tag store
    output cachePkg::addrT addr,
    input  logic hit,
    input  logic hitWay,
    input  logic victimWay,
    output logic tagWrite,
    output logic tagWay,
    output logic touch,
    output logic touchWay,
    // Data store
    output logic fillValid,
    output logic fillWay,
    output cachePkg::wordSelT fillSel,
    output cachePkg::wordT fillData,
    output logic wordWrite,
    output logic writeWay,
    output cachePkg::wordT writeData,
    output logic readWay,
    input  cachePkg::wordT readWord
);

    localparam int lineOffsetBits = cachePkg::wordOffsetBits + cachePkg::byteOffsetBits;
    localparam int tagWidth = cachePkg::addrWidth - setIndexBits - lineOffsetBits;

    cachePkg::cacheStateT state;
    cachePkg::cacheStateT nextState;
    // Accepted request, held until the response completes
    cachePkg::coreReqT reqReg;
    // Way chosen for the fill
    logic fillWayReg;
    cachePkg::wordSelT beatCount;
    cachePkg::wordSelT reqWordSel;
    cachePkg::addrT lineAddr;
    logic lastBeat;

    assign addr = reqReg.addr;
    assign reqWordSel = reqReg.addr[cachePkg::byteOffsetBits +: cachePkg::wordOffsetBits];
    // Tag and index with the line offset zeroed
    assign lineAddr = {reqReg.addr[cachePkg::addrWidth-1 -: tagWidth],
                       reqReg.addr[lineOffsetBits +: setIndexBits],
                       lineOffsetBits'(0)};
    assign lastBeat = (state == cachePkg::stFill) && memRespValid &&
                      (beatCount == cachePkg::wordSelT'(cachePkg::lineWords - 1));

    // Next state
    always_comb begin
        nextState = state;
        case (state)
            cachePkg::stIdle:
                if (coreReqValid && coreReqReady) nextState = cachePkg::stLookup;
            cachePkg::stLookup:
                // Writes always go to memory, hits are updated on the way
                if (reqReg.isWrite) nextState = cachePkg::stWriteMem;
                else if (hit) nextState = cachePkg::stRespond;
                else nextState = cachePkg::stFillReq;
            cachePkg::stFillReq:
                if (memReqReady) nextState = cachePkg::stFill;
            cachePkg::stFill:
                if (lastBeat) nextState = cachePkg::stRespond;
            cachePkg::stWriteMem:
                if (memReqReady) nextState = cachePkg::stRespond;
            cachePkg::stRespond:
                if (coreRespValid && coreRespReady) nextState = cachePkg::stIdle;
            default:
                nextState = cachePkg::stIdle;
        endcase
    end

    // Memory request straight from the latched request
    assign memReqValid = (state == cachePkg::stFillReq) || (state == cachePkg::stWriteMem);
    assign memReq.addr = reqReg.isWrite ? reqReg.addr : lineAddr;
    assign memReq.writeData = reqReg.isWrite ? reqReg.writeData : '0;
    assign memReq.isWrite = reqReg.isWrite;

    // Tag install and LRU update
    assign tagWrite = lastBeat;
    assign tagWay = fillWayReg;
    assign touch = ((state == cachePkg::stLookup) && hit) || lastBeat;
    assign touchWay = lastBeat ? fillWayReg : hitWay;

    // Fill beats land in the victim way
    assign fillValid = (state == cachePkg::stFill) && memRespValid;
    assign fillWay = fillWayReg;
    assign fillSel = beatCount;
    assign fillData = memRespData;

    // Write hit updates the word in place
    assign wordWrite = (state == cachePkg::stLookup) && reqReg.isWrite && hit;
    assign writeWay = hitWay;
    assign writeData = reqReg.writeData;
    assign readWay = hitWay;

    // Control state
    always_ff @(posedge rwArbiterCacheBus) begin
        if (rst) begin
            state <= cachePkg::stIdle;
            coreReqReady <= 1'b0;
            coreRespValid <= 1'b0;
            beatCount <= '0;
        end else begin
            state <= nextState;
            // Ready only while idle
            coreReqReady <= (nextState == cachePkg::stIdle);
            if (state == cachePkg::stFillReq) begin
                beatCount <= '0;
            end else if (fillValid) begin
                beatCount <= beatCount + 1'b1;
            end
            // Response rises after the last beat, the write handshake, or the hit read
            if (lastBeat) begin
                coreRespValid <= 1'b1;
            end else if ((state == cachePkg::stWriteMem) && memReqReady) begin
                coreRespValid <= 1'b1;
            end else if (state == cachePkg::stRespond) begin
                coreRespValid <= !(coreRespValid && coreRespReady);
            end
        end
    end

    // Payload registers
    always_ff @(posedge rwArbiterCacheBus) begin
        if (coreReqValid && coreReqReady) begin
            reqReg <= coreReq;
        end
        if (state == cachePkg::stLookup) begin
            fillWayReg <= victimWay;
        end
        // Keep the requested word as it streams past
        if (fillValid && (beatCount == reqWordSel)) begin
            coreRespData <= memRespData;
        end
        // Write responses carry no data
        if ((state == cachePkg::stWriteMem) && memReqReady) begin
            coreRespData <= '0;
        end
        // Hit data from the registered read, once
        if ((state == cachePkg::stRespond) && !coreRespValid) begin
            coreRespData <= readWord;
        end
    end

endmodule

//--- cacheDataStore.sv
`timescale 1ns/1ps

module cacheDataStore #(
    parameter int setIndexBits = 4
) (
    input  logic rwArbiterCacheBus,
    input  cachePkg::addrT addr,
    input  logic readWay,
    output cachePkg::wordT readWord,
    input  logic fillValid,
    input  logic fillWay,
    input  cachePkg::wordSelT fillSel,
    input  cachePkg::wordT fillData,
    input  logic wordWrite,
    input  logic writeWay,
    input  cachePkg::wordT writeData
);

    localparam int lineOffsetBits = cachePkg::wordOffsetBits + cachePkg::byteOffsetBits;
    localparam int numSets = 1 << setIndexBits;

    // Line storage, way by set by word
    cachePkg::wordT lineArray [2][numSets][cachePkg::lineWords];

    logic [setIndexBits-1:0] setIndex;
    cachePkg::wordSelT wordSel;

    // Set index and word offset of the current request
    assign setIndex = addr[lineOffsetBits +: setIndexBits];
    assign wordSel = addr[cachePkg::byteOffsetBits +: cachePkg::wordOffsetBits];

    // Fill beats and write hits never overlap
    always_ff @(posedge rwArbiterCacheBus) begin
        if (fillValid) begin
            // Fill beat goes to the victim way at its beat position
            lineArray[fillWay][setIndex][fillSel] <= fillData;
        end else if (wordWrite) begin
            // Write hit replaces one word in place
            lineArray[writeWay][setIndex][wordSel] <= writeData;
        end
    end

    // Registered word select, one clock of latency
    always_ff @(posedge rwArbiterCacheBus) begin
        readWord <= lineArray[readWay][setIndex][wordSel];
    end

endmodule

//--- cachePkg.sv
package cachePkg;

    // Data word and byte address widths
    localparam int wordWidth = 64;
    localparam int addrWidth = 32;

    // Eight words per line, so a line is 64 bytes
    localparam int lineWords = 8;
    localparam int wordOffsetBits = 3;
    localparam int byteOffsetBits = 3;

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [addrWidth-1:0] addrT;
    // Index of a word inside a line
    typedef logic [wordOffsetBits-1:0] wordSelT;

    // Request from the core
    typedef struct packed {
        addrT addr;
        wordT writeData;
        logic isWrite;
    } coreReqT;

    // Request to memory
    // Fill requests carry a line aligned address
    typedef struct packed {
        addrT addr;
        wordT writeData;
        logic isWrite;
    } memReqT;

    // Controller states
    typedef enum logic [2:0] {
        stIdle,
        stLookup,
        stFillReq,
        stFill,
        stWriteMem,
        stRespond
    } cacheStateT;

endpackage

//--- cacheTagStore.sv
`timescale 1ns/1ps

module cacheTagStore #(
    parameter int setIndexBits = 4
) (
    input  logic rwArbiterCacheBus,
    input  logic rst,
    input  cachePkg::addrT addr,
    output logic hit,
    output logic hitWay,
    output logic victimWay,
    input  logic tagWrite,
    input  logic tagWay,
    input  logic touch,
    input  logic touchWay
);

    // Byte offset plus word offset inside a line
    localparam int lineOffsetBits = cachePkg::wordOffsetBits + cachePkg::byteOffsetBits;
    localparam int tagWidth = cachePkg::addrWidth - setIndexBits - lineOffsetBits;
    localparam int numSets = 1 << setIndexBits;

    // Tag array, one entry per way and set
    logic [tagWidth-1:0] tagArray [2][numSets];
    // Valid bits, one vector per way
    logic [numSets-1:0] validBits [2];
    // Most recently used way of each set
    logic [numSets-1:0] mruBits;

    logic [setIndexBits-1:0] setIndex;
    logic [tagWidth-1:0] addrTag;
    logic [1:0] wayHit;

    // Split the address into tag and set index
    assign setIndex = addr[lineOffsetBits +: setIndexBits];
    assign addrTag = addr[cachePkg::addrWidth-1 -: tagWidth];

    // Compare both ways in parallel
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = validBits[w][setIndex] && (tagArray[w][setIndex] == addrTag);
        end
    end

    assign hit = |wayHit;
    // Way 1 wins the encode, both ways never hold the same tag
    assign hitWay = wayHit[1];
    // Victim is the way that was not used last
    assign victimWay = ~mruBits[setIndex];

    // Tag install at the end of a fill
    always_ff @(posedge rwArbiterCacheBus) begin
        if (tagWrite) begin
            tagArray[tagWay][setIndex] <= addrTag;
        end
    end

    // Valid and LRU bookkeeping
    always_ff @(posedge rwArbiterCacheBus) begin
        if (rst) begin
            validBits[0] <= '0;
            validBits[1] <= '0;
            mruBits <= '0;
        end else begin
            if (tagWrite) begin
                validBits[tagWay][setIndex] <= 1'b1;
            end
            // Mark the touched way as most recently used
            if (touch) begin
                mruBits[setIndex] <= touchWay;
            end
        end
    end

endmodule

//--- setAssocCache.sv
`timescale 1ns/1ps

module setAssocCache #(
    parameter int setIndexBits = 4
) (
    input  logic rwArbiterCacheBus,
    input  logic rst,
    // Core side
    input  cachePkg::coreReqT coreReq,
    input  logic coreReqValid,
    output logic coreReqReady,
    output cachePkg::wordT coreRespData,
    output logic coreRespValid,
    input  logic coreRespReady,
    // Memory side
    output cachePkg::memReqT memReq,
    output logic memReqValid,
    input  logic memReqReady,
    input  cachePkg::wordT memRespData,
    input  logic memRespValid
);

    // Lookup links
    cachePkg::addrT addr;
    logic hit;
    logic hitWay;
    logic victimWay;
    logic tagWrite;
    logic tagWay;
    logic touch;
    logic touchWay;
    // Data store links
    logic fillValid;
    logic fillWay;
    cachePkg::wordSelT fillSel;
    cachePkg::wordT fillData;
    logic wordWrite;
    logic writeWay;
    cachePkg::wordT writeData;
    logic readWay;
    cachePkg::wordT readWord;

    cacheTagStore #(.setIndexBits(setIndexBits)) tagStore_inst (
        .rwArbiterCacheBus(rwArbiterCacheBus), .rst(rst), .addr(addr),
        .hit(hit), .hitWay(hitWay), .victimWay(victimWay),
        .tagWrite(tagWrite), .tagWay(tagWay), .touch(touch), .touchWay(touchWay)
    );

    cacheDataStore #(.setIndexBits(setIndexBits)) dataStore_inst (
        .rwArbiterCacheBus(rwArbiterCacheBus), .addr(addr),
        .readWay(readWay), .readWord(readWord),
        .fillValid(fillValid), .fillWay(fillWay), .fillSel(fillSel), .fillData(fillData),
        .wordWrite(wordWrite), .writeWay(writeWay), .writeData(writeData)
    );

    cacheController #(.setIndexBits(setIndexBits)) controller_inst (
        .rwArbiterCacheBus(rwArbiterCacheBus), .rst(rst),
        .coreReq(coreReq), .coreReqValid(coreReqValid), .coreReqReady(coreReqReady),
        .coreRespData(coreRespData), .coreRespValid(coreRespValid),
        .coreRespReady(coreRespReady),
        .memReq(memReq), .memReqValid(memReqValid), .memReqReady(memReqReady),
        .memRespData(memRespData), .memRespValid(memRespValid),
        .addr(addr), .hit(hit), .hitWay(hitWay), .victimWay(victimWay),
        .tagWrite(tagWrite), .tagWay(tagWay), .touch(touch), .touchWay(touchWay),
        .fillValid(fillValid), .fillWay(fillWay), .fillSel(fillSel), .fillData(fillData),
        .wordWrite(wordWrite), .writeWay(writeWay), .writeData(writeData),
        .readWay(readWay), .readWord(readWord)
    );

endmodule

//--- tbSetAssocCache.sv
`timescale 1ns/1ps

module tbSetAssocCache;

    localparam int setIndexBits = 4;
    localparam int numSets = 1 << setIndexBits;
    // Byte offset plus word offset
    localparam int lineShift = 6;
    localparam int tagShift = lineShift + setIndexBits;
    localparam int timeoutCycles = 200;
    localparam int numRandomTxns = 300;

    logic rwArbiterCacheBus = 1'b0;
    logic rst = 1'b1;
    cachePkg::coreReqT coreReq = '0;
    logic coreReqValid = 1'b0;
    logic coreReqReady;
    cachePkg::wordT coreRespData;
    logic coreRespValid;
    logic coreRespReady = 1'b0;
    cachePkg::memReqT memReq;
    logic memReqValid;
    logic memReqReady = 1'b0;
    cachePkg::wordT memRespData = '0;
    logic memRespValid = 1'b0;

    // Memory contents as seen by the responder
    cachePkg::wordT memArray [cachePkg::addrT];
    // Requests taken by memory during the current transaction
    cachePkg::memReqT memReqLog [$];
    int beatsLeft = 0;
    cachePkg::addrT fillBase;
    cachePkg::addrT fillAddr;

    // Reference model: expected memory, tags, valid bits and LRU way per set
    cachePkg::wordT refMem [cachePkg::addrT];
    int refTag [numSets][2];
    bit refValid [numSets][2];
    bit refLru [numSets];

    setAssocCache #(.setIndexBits(setIndexBits)) setAssocCache_inst (
        .rwArbiterCacheBus(rwArbiterCacheBus), .rst(rst),
        .coreReq(coreReq), .coreReqValid(coreReqValid), .coreReqReady(coreReqReady),
        .coreRespData(coreRespData), .coreRespValid(coreRespValid),
        .coreRespReady(coreRespReady),
        .memReq(memReq), .memReqValid(memReqValid), .memReqReady(memReqReady),
        .memRespData(memRespData), .memRespValid(memRespValid)
    );

    initial begin
        forever #10 rwArbiterCacheBus = ~rwArbiterCacheBus;
    end

    // Starting memory contents, both halves depend on the whole address
    function automatic cachePkg::wordT defaultWord(input cachePkg::addrT a);
        return {a ^ 32'h5a5a_0f0f, (a * 32'h9e37_79b9) + 32'h0123_4567};
    endfunction

    function automatic cachePkg::addrT makeAddr(input int tag, input int idx, input int word);
        return cachePkg::addrT'((tag << tagShift) | (idx << lineShift) | (word << 3));
    endfunction

    task automatic checkEq(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got %h expected %h", $time, what, actual,
                     expected);
            $display("Finished with errors");
            $fatal(1, "check failed");
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout while %s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    // Predict hit or miss, then apply LRU replacement to the model
    function automatic bit modelAccess(input cachePkg::addrT a, input bit isWrite);
        int set;
        int tag;
        bit hit;
        bit way;
        set = (a >> lineShift) % numSets;
        tag = a >> tagShift;
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (refValid[set][w] && refTag[set][w] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (hit) begin
            refLru[set] = !way;
        end else if (!isWrite) begin
            // Read miss fills the LRU way, write miss allocates nothing
            way = refLru[set];
            refTag[set][way] = tag;
            refValid[set][way] = 1'b1;
            refLru[set] = !way;
        end
        return hit;
    endfunction

    // One core transaction with response back-pressure
    task automatic runTxn(input cachePkg::addrT a, input bit isWrite,
                          input cachePkg::wordT data, input int expectHit);
        bit predHit;
        cachePkg::wordT expData;
        cachePkg::wordT heldData;
        int waitCount;
        int holdCycles;
        predHit = modelAccess(a, isWrite);
        if (expectHit >= 0) begin
            checkEq(64'(predHit), 64'(expectHit), "model hit prediction");
        end
        if (isWrite) begin
            refMem[a] = data;
            expData = '0;
        end else begin
            expData = refMem.exists(a) ? refMem[a] : defaultWord(a);
        end
        coreReq.addr <= a;
        coreReq.writeData <= data;
        coreReq.isWrite <= isWrite;
        coreReqValid <= 1'b1;
        // Acceptance
        waitCount = 0;
        @(posedge rwArbiterCacheBus);
        while (!coreReqReady) begin
            waitCount++;
            if (waitCount > timeoutCycles) timeoutFail("waiting for coreReqReady");
            @(posedge rwArbiterCacheBus);
        end
        coreReqValid <= 1'b0;
        // Response, no new request may be taken meanwhile
        waitCount = 1;
        @(posedge rwArbiterCacheBus);
        while (!coreRespValid) begin
            checkEq(64'(coreReqReady), 64'(0), "coreReqReady while busy");
            if (waitCount > timeoutCycles) timeoutFail("waiting for coreRespValid");
            @(posedge rwArbiterCacheBus);
            waitCount++;
        end
        if (predHit && !isWrite) begin
            checkEq(64'(waitCount), 64'(3), "read hit latency in cycles");
        end
        heldData = coreRespData;
        // Hold the response back for a random time
        holdCycles = $urandom_range(0, 4);
        for (int i = 0; i < holdCycles; i++) begin
            @(posedge rwArbiterCacheBus);
            checkEq(64'(coreRespValid), 64'(1), "coreRespValid under back-pressure");
            checkEq(coreRespData, heldData, "coreRespData under back-pressure");
            checkEq(64'(coreReqReady), 64'(0), "coreReqReady under back-pressure");
        end
        coreRespReady <= 1'b1;
        @(posedge rwArbiterCacheBus);
        checkEq(64'(coreRespValid), 64'(1), "coreRespValid at handshake");
        coreRespReady <= 1'b0;
        checkEq(heldData, expData, isWrite ? "write response data" : "read data");
        // Memory traffic of this transaction
        if (isWrite) begin
            checkEq(64'(memReqLog.size()), 64'(1), "memReq count for write");
            checkEq(64'(memReqLog[0].isWrite), 64'(1), "memReq isWrite for write");
            checkEq(64'(memReqLog[0].addr), 64'(a), "memReq address for write");
            checkEq(memReqLog[0].writeData, data, "memReq data for write");
        end else if (predHit) begin
            checkEq(64'(memReqLog.size()), 64'(0), "memReq count for read hit");
        end else begin
            checkEq(64'(memReqLog.size()), 64'(1), "memReq count for read miss");
            checkEq(64'(memReqLog[0].isWrite), 64'(0), "memReq isWrite for fill");
            checkEq(64'(memReqLog[0].addr), 64'({a[31:6], 6'b0}), "fill address");
        end
        memReqLog.delete();
    endtask

    // Memory model: random ready delay, eight fill beats with random gaps
    always @(posedge rwArbiterCacheBus) begin
        if (rst) begin
            memReqReady <= 1'b0;
            memRespValid <= 1'b0;
            beatsLeft = 0;
        end else if (beatsLeft > 0) begin
            if ($urandom_range(0, 2) == 0) begin
                memRespValid <= 1'b0;
            end else begin
                fillAddr = fillBase + cachePkg::addrT'((cachePkg::lineWords - beatsLeft) * 8);
                memRespData <= memArray.exists(fillAddr) ? memArray[fillAddr]
                                                         : defaultWord(fillAddr);
                memRespValid <= 1'b1;
                beatsLeft--;
            end
        end else if (memReqValid && memReqReady) begin
            memReqLog.push_back(memReq);
            memReqReady <= 1'b0;
            memRespValid <= 1'b0;
            if (memReq.isWrite) begin
                memArray[memReq.addr] = memReq.writeData;
            end else begin
                fillBase = memReq.addr;
                beatsLeft = cachePkg::lineWords;
            end
        end else begin
            memRespValid <= 1'b0;
            memReqReady <= memReqValid && ($urandom_range(0, 3) == 0);
        end
    end

    initial begin
        int tagPick;
        int idxPick;
        int wordPick;
        bit isWrite;
        cachePkg::wordT data;
        void'($urandom(85));
        repeat (5) @(posedge rwArbiterCacheBus);
        rst <= 1'b0;
        // Tags A B C in one set, first reads after reset miss
        runTxn(makeAddr(4, 9, 0), 1'b0, '0, 0);
        runTxn(makeAddr(5, 9, 1), 1'b0, '0, 0);
        runTxn(makeAddr(4, 9, 2), 1'b0, '0, 1);
        // C evicts B since A was used last
        runTxn(makeAddr(6, 9, 3), 1'b0, '0, 0);
        runTxn(makeAddr(4, 9, 4), 1'b0, '0, 1);
        runTxn(makeAddr(5, 9, 5), 1'b0, '0, 0);
        // Write hit then read back the new word
        runTxn(makeAddr(4, 9, 2), 1'b1, 64'hfeed_beef_0bad_cafe, 1);
        runTxn(makeAddr(4, 9, 2), 1'b0, '0, 1);
        // Random mix over 3 tags, 2 sets, 8 words
        for (int n = 0; n < numRandomTxns; n++) begin
            tagPick = $urandom_range(1, 3);
            idxPick = ($urandom_range(0, 1) == 0) ? 2 : 12;
            wordPick = $urandom_range(0, 7);
            isWrite = ($urandom_range(0, 9) < 3);
            data = {$urandom, $urandom};
            runTxn(makeAddr(tagPick, idxPick, wordPick), isWrite, data, -1);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- tbSetAssocCache_assertions.sv
`timescale 1ns/1ps

module tbSetAssocCache_assertions (
    input logic rwArbiterCacheBus,
    input logic rst,
    input cachePkg::memReqT memReq,
    input logic memReqValid,
    input logic memReqReady,
    input logic coreReqReady,
    input logic coreRespValid,
    input logic coreRespReady
);

    // Memory request held stable until memory takes it
    memReqHeld: assert property (
        @(posedge rwArbiterCacheBus) disable iff (rst)
        memReqValid && !memReqReady |=> memReqValid && $stable(memReq)
    ) else $error("memReq dropped or changed before memReqReady");

    // Core response held until the core takes it
    coreRespHeld: assert property (
        @(posedge rwArbiterCacheBus) disable iff (rst)
        coreRespValid && !coreRespReady |=> coreRespValid
    ) else $error("coreRespValid dropped before coreRespReady");

    // No new request while a response is pending
    noAcceptDuringResp: assert property (
        @(posedge rwArbiterCacheBus) disable iff (rst)
        coreRespValid |-> !coreReqReady
    ) else $error("coreReqReady high while coreRespValid is high");

endmodule

bind setAssocCache tbSetAssocCache_assertions assertions_inst (
    .rwArbiterCacheBus(rwArbiterCacheBus), .rst(rst),
    .memReq(memReq), .memReqValid(memReqValid), .memReqReady(memReqReady),
    .coreReqReady(coreReqReady), .coreRespValid(coreRespValid),
    .coreRespReady(coreRespReady)
);

//--- vlog.f
cachePkg.sv
cacheTagStore.sv
cacheDataStore.sv
cacheController.sv
setAssocCache.sv
tbSetAssocCache_assertions.sv
tbSetAssocCache.sv
